//--- filelist.f
dmm_pkg.sv
clk_counter.sv
adc_mock.sv
sequence_acquisition.sv
spi_register_set.sv
pin_mux.sv
dmm_top.sv
tb_clk_gen.sv
tb_dmm_props.sv
tb_dmm_top.sv

//--- Bender.yml
package:
  name: dmm_ctrl

sources:
  - dmm_pkg.sv
  - clk_counter.sv
  - adc_mock.sv
  - sequence_acquisition.sv
  - spi_register_set.sv
  - pin_mux.sv
  - dmm_top.sv
  - target: simulation
    files:
      - tb_clk_gen.sv
      - tb_dmm_props.sv
      - tb_dmm_top.sv

//--- tb_dmm_top.sv
/* dmm control fpga testbench */
module tb_dmm_top import dmm_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_TRANS   = 40;    // spi frames rounded up
  localparam int N_SAMPLES = 9;
  localparam int PRECHARGE = 20;
  localparam int APERTURE  = 30;
  localparam int TIMEOUT_CYCLES =
    2 * (N_TRANS * FRAME_W * 4 + N_SAMPLES * (PRECHARGE + APERTURE + 4));

  typedef struct packed {
    logic glb_clk;
    logic glb_mosi;
    logic strobe_4094;      // active hi
    logic invert_dac_ss;    // active lo from here down
    logic iso_cs;
  } cs_out_t;

  logic                  clk_i;
  logic                  rst_n_i;
  logic                  sck_i;
  logic                  sdi_i;
  logic                  sdo_o;
  logic [CS_W-1:0]       spi_cs_vec_i;
  logic [HW_FLAGS_W-1:0] hw_flags_i;
  logic                  sa_trig_i;
  logic                  spi_4094_oe_o;
  cs_out_t               cs_out;
  out_pins_t             pins;

  integer            seed;
  logic [DATA_W-1:0] reg_m [16];      // last written values unmasked
  logic [IDX_W-1:0]  last_idx_m;
  logic [IDX_W-1:0]  exp_idx;
  int                sample_cnt;
  int                pc_cycles;       // precharge length seen on monitor_o[0]
  int                cycle_cnt = 0;
  bit                pins_chk_en;     // pin word and oe checked every cycle
  bit                seq_chk_en;
  logic [DATA_W-1:0] rd_exp_q [$];
  logic [DATA_W-1:0] rd_act_q [$];

  tb_clk_gen u_clk_gen (.clk_o(clk_i), .rst_n_o(rst_n_i));

  dmm_top u_dmm_top (
    .clk_i               (clk_i),
    .rst_n_i             (rst_n_i),
    .sck_i               (sck_i),
    .sdi_i               (sdi_i),
    .sdo_o               (sdo_o),
    .spi_cs_vec_i        (spi_cs_vec_i),
    .hw_flags_i          (hw_flags_i),
    .sa_trig_i           (sa_trig_i),
    .spi_glb_clk_o       (cs_out.glb_clk),
    .spi_glb_mosi_o      (cs_out.glb_mosi),
    .spi_4094_strobe_o   (cs_out.strobe_4094),
    .spi_4094_oe_o       (spi_4094_oe_o),
    .spi_invert_dac_ss_o (cs_out.invert_dac_ss),
    .spi_iso_cs_o        (cs_out.iso_cs),
    .leds_o              (pins.leds),
    .monitor_o           (pins.monitor),
    .pc_sw_o             (pins.pc_sw),
    .azmux_o             (pins.azmux),
    .meas_complete_o     (pins.meas_complete),
    .spi_interrupt_o     (pins.spi_interrupt)
  );

  //////////////////////////////////////////////////
  // reference model
  function automatic int seq_len_of(input logic [SEQ_N_W-1:0] n);
    if (n == '0) return 1;
    if (n > 3'd4) return 4;    // full table
    return int'(n);
  endfunction

  function automatic logic [DATA_W-1:0] predict_reg(input logic [ADDR_W-1:0] addr);
    logic [DATA_W-1:0] v;
    v = reg_m[addr[3:0]];
    case (addr)
      REG_STATUS:
        return {5'd0, reg_m[REG_SEQ_N][2:0], 2'd0, last_idx_m, hw_flags_i, 8'haa};
      REG_MODE, REG_SEQ_N:         return v & 24'h7;
      REG_DIRECT:                  return v & 24'hf_ffff;
      REG_4094_OE:                 return v & 24'h1;
      REG_PRECHARGE, REG_APERTURE: return v;
      REG_SEQ0, REG_SEQ1, REG_SEQ2, REG_SEQ3: return v & 24'h3f;
      default:                     return '0;
    endcase
  endfunction

  // mode 6 word as seen on a completion strobe
  function automatic out_pins_t predict_pins(input logic [MODE_W-1:0] mode,
                                             input logic [PIN_W-1:0] direct,
                                             input logic [5:0] entry,
                                             input logic [IDX_W-1:0] idx);
    out_pins_t p;
    p = '0;
    if (mode == 3'd0) begin
      p = out_pins_t'(direct);
    end else if (mode == 3'd6) begin
      p.leds          = 4'd1 << idx;
      p.monitor       = 8'h06;        // valid and adc running
      p.azmux         = entry[5:2];
      p.pc_sw         = entry[1:0];
      p.meas_complete = 1'b1;
      p.spi_interrupt = 1'b1;
    end
    return p;
  endfunction

  function automatic cs_out_t predict_cs(input logic [CS_W-1:0] vec,
                                         input logic sck, input logic sdi);
    cs_out_t c;
    c.glb_clk       = (vec == CS_FPGA0) ? 1'b1 : sck;   // parked for the fpga
    c.glb_mosi      = (vec == CS_FPGA0) ? 1'b1 : sdi;
    c.strobe_4094   = (vec == CS_4094);
    c.invert_dac_ss = (vec != CS_INVERT_DAC);
    c.iso_cs        = (vec != CS_MDAC1);
    return c;
  endfunction

  //////////////////////////////////////////////////
  // compare tasks
  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_pins(input string name, input out_pins_t act, input out_pins_t exp);
    if (act !== exp) report_failure($sformatf("FAILED %s: got %h, expected %h", name, act, exp));
  endtask

  task automatic check_word(input string name, input logic [DATA_W-1:0] act,
                            input logic [DATA_W-1:0] exp);
    if (act !== exp) report_failure($sformatf("FAILED %s: got %h, expected %h", name, act, exp));
  endtask

  task automatic check_cs(input string name, input cs_out_t act, input cs_out_t exp);
    if (act !== exp) report_failure($sformatf("FAILED %s: got %h, expected %h", name, act, exp));
  endtask

  //////////////////////////////////////////////////
  // spi bit-bang at 4 clk per bit
  task automatic shift_frame(input spi_frame_t frame, output logic [DATA_W-1:0] rd);
    rd = '0;
    @(posedge clk_i);
    spi_cs_vec_i <= CS_FPGA0;
    sck_i        <= 1'b0;
    for (int i = FRAME_W - 1; i >= 0; i--) begin
      @(posedge clk_i);
      sdi_i <= frame[i];
      sck_i <= 1'b0;
      @(posedge clk_i);
      @(posedge clk_i);
      if (i < DATA_W) rd[i] = sdo_o;    // settled since the falling edge
      sck_i <= 1'b1;
      @(posedge clk_i);
    end
    sck_i <= 1'b0;
    @(posedge clk_i);
    spi_cs_vec_i <= CS_DEASSERT;
    sdi_i        <= 1'b0;
    @(posedge clk_i);
  endtask

  task automatic spi_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    logic [DATA_W-1:0] unused_rd;
    shift_frame({1'b1, addr, data}, unused_rd);
    if (addr != REG_STATUS) reg_m[addr[3:0]] = data;
  endtask

  task automatic spi_read(input logic [ADDR_W-1:0] addr);
    logic [DATA_W-1:0] rd;
    shift_frame({1'b0, addr, 24'h0}, rd);
    rd_exp_q.push_back(predict_reg(addr));
    rd_act_q.push_back(rd);
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk_i);
  endtask

  //////////////////////////////////////////////////
  // compare process sampling mid cycle
  always @(negedge clk_i) begin
    check_cs("spi select outputs", cs_out, predict_cs(spi_cs_vec_i, sck_i, sdi_i));
    if (pins_chk_en) begin
      check_pins("pins", pins, predict_pins(reg_m[REG_MODE][2:0], reg_m[REG_DIRECT][19:0],
                                            '0, '0));
      check_word("spi_4094_oe_o", DATA_W'(spi_4094_oe_o), predict_reg(REG_4094_OE));
    end
    if (seq_chk_en && pins.spi_interrupt) begin
      check_pins("pins at spi_interrupt", pins,
                 predict_pins(reg_m[REG_MODE][2:0], '0,
                              reg_m[int'(REG_SEQ0) + int'(exp_idx)][5:0], exp_idx));
      last_idx_m = exp_idx;
      exp_idx    = IDX_W'((int'(exp_idx) + 1) % seq_len_of(reg_m[REG_SEQ_N][2:0]));
      sample_cnt++;
    end
    // a full precharge is followed by the adc running
    if (seq_chk_en) begin
      if (pins.monitor[0]) begin
        pc_cycles++;
      end else begin
        if ((pc_cycles != 0) && pins.monitor[2]) begin
          check_word("monitor_o[0] cycles", DATA_W'(pc_cycles), DATA_W'(PRECHARGE));
        end
        pc_cycles = 0;
      end
    end
    while (rd_act_q.size() != 0) begin
      check_word("spi read data", rd_act_q.pop_front(), rd_exp_q.pop_front());
    end
    if (u_dmm_top.u_sequence_acquisition.u_seq_props.fail_cnt != 0) begin
      report_failure("a sequencer assertion failed");
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) report_failure("timeout, the tests did not finish in time");
  end

  //////////////////////////////////////////////////
  // stimulus
  initial begin
    seed         = 32'hbea2;
    sck_i        = 1'b0;
    sdi_i        = 1'b0;
    spi_cs_vec_i = CS_DEASSERT;
    hw_flags_i   = '0;
    sa_trig_i    = 1'b0;
    for (int a = 0; a < 16; a++) reg_m[a] = '0;
    last_idx_m  = '0;
    exp_idx     = '0;
    sample_cnt  = 0;
    pc_cycles   = 0;
    pins_chk_en = 1'b1;    // reset state is all low
    seq_chk_en  = 1'b0;
    @(posedge rst_n_i);
    wait_cycles(4);
    hw_flags_i <= 4'($random(seed));

    // every select code with all sck/sdi combinations
    for (int v = 0; v < 8; v++) begin
      @(posedge clk_i);
      spi_cs_vec_i <= 3'(v);
      sck_i        <= 1'b0;
      sdi_i        <= 1'b0;
      @(posedge clk_i);
      sck_i <= 1'b1;
      sdi_i <= 1'b1;
      @(posedge clk_i);
      sck_i <= 1'b0;
      @(posedge clk_i);
      sck_i <= 1'b1;
      sdi_i <= 1'b0;
    end
    @(posedge clk_i);
    spi_cs_vec_i <= CS_DEASSERT;
    sck_i        <= 1'b0;

    // register readback
    pins_chk_en = 1'b0;
    for (int a = 1; a <= 10; a++) spi_write(7'(a), 24'($random(seed)));
    for (int a = 0; a <= 10; a++) spi_read(7'(a));

    // direct and unused mode
    spi_write(REG_MODE, 24'd0);
    spi_write(REG_DIRECT, 24'($random(seed)));
    pins_chk_en = 1'b1;
    wait_cycles(8);
    pins_chk_en = 1'b0;
    spi_write(REG_DIRECT, 24'($random(seed)));
    pins_chk_en = 1'b1;
    wait_cycles(8);
    pins_chk_en = 1'b0;
    spi_write(REG_MODE, 24'd5);
    pins_chk_en = 1'b1;
    wait_cycles(8);
    pins_chk_en = 1'b0;

    // sequence of length 3 with the mocked adc
    spi_write(REG_PRECHARGE, 24'(PRECHARGE));
    spi_write(REG_APERTURE, 24'(APERTURE));
    spi_write(REG_SEQ_N, 24'd3);
    for (int s = 0; s < SEQ_LEN_MAX; s++) spi_write(REG_SEQ0 + 7'(s), 24'($random(seed)));
    spi_write(REG_MODE, 24'd6);
    exp_idx    = '0;
    sample_cnt = 0;
    pc_cycles  = 0;
    seq_chk_en = 1'b1;
    @(posedge clk_i);
    sa_trig_i <= 1'b1;
    while (sample_cnt < N_SAMPLES) @(posedge clk_i);
    sa_trig_i <= 1'b0;
    wait_cycles(4);     // sync plus return to idle
    seq_chk_en = 1'b0;
    spi_read(REG_STATUS);
    wait_cycles(2);

    $display("No errors");
    $finish;
  end

endmodule

//--- tb_dmm_props.sv
/* sequencer assertions */
module tb_dmm_props import dmm_pkg::*; (
  input logic               clk_i,
  input logic               rst_n_i,
  input logic               trig_i,           // synchronized trigger
  input logic               precharge_i,
  input logic               adc_reset_n_i,
  input logic               meas_complete_i,
  input logic [PC_SW_W-1:0] pc_sw_i,
  input logic [AZMUX_W-1:0] azmux_i
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_cnt = 0;    // polled from the testbench

  // completion is a single strobe
  meas_complete_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    meas_complete_i |=> !meas_complete_i)
  else begin
    fail_cnt++;
    $error("meas_complete held for more than one cycle");
  end

  // switches open while idle
  idle_outputs_low: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !trig_i |-> (pc_sw_i == '0) && (azmux_i == '0))
  else begin
    fail_cnt++;
    $error("pc_sw or azmux driven with the trigger low");
  end

  precharge_adc_reset: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    precharge_i |-> !adc_reset_n_i)    // adc held in reset
  else begin
    fail_cnt++;
    $error("adc reset released during precharge");
  end

endmodule

bind sequence_acquisition tb_dmm_props u_seq_props (
  .clk_i           (clk_i),
  .rst_n_i         (rst_n_i),
  .trig_i          (trig_q),
  .precharge_i     (precharge_o),
  .adc_reset_n_i   (adc_reset_n_o),
  .meas_complete_i (meas_complete_o),
  .pc_sw_i         (pc_sw_o),
  .azmux_i         (azmux_o)
);

//--- tb_clk_gen.sv
/* testbench clock and reset */
module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam time HALF_PERIOD  = 50ns;    // 100 ns clock
  localparam int  RESET_CYCLES = 10;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;    // release on an edge
  end

endmodule

//--- dmm_top.sv
/* dmm control fpga top */
module dmm_top import dmm_pkg::*; (
  input  logic                  clk_i,          // xtal
  input  logic                  rst_n_i,
  // spi
  input  logic                  sck_i,
  input  logic                  sdi_i,
  output logic                  sdo_o,
  input  logic [CS_W-1:0]       spi_cs_vec_i,
  input  logic [HW_FLAGS_W-1:0] hw_flags_i,
  input  logic                  sa_trig_i,
  output logic                  spi_glb_clk_o,
  output logic                  spi_glb_mosi_o,
  output logic                  spi_4094_strobe_o,
  output logic                  spi_4094_oe_o,
  output logic                  spi_invert_dac_ss_o,
  output logic                  spi_iso_cs_o,
  // pins
  output logic [LED_W-1:0]      leds_o,
  output logic [MON_W-1:0]      monitor_o,
  output logic [PC_SW_W-1:0]    pc_sw_o,
  output logic [AZMUX_W-1:0]    azmux_o,
  output logic                  meas_complete_o,
  output logic                  spi_interrupt_o
);

  logic               cs_fpga_n;
  sa_cfg_t            sa_cfg;
  sa_status_t         sa_status;
  logic [MODE_W-1:0]  mode;
  pin_word_u          direct;
  logic [PC_SW_W-1:0] sa_pc_sw;
  logic [AZMUX_W-1:0] sa_azmux;
  logic               sa_adc_reset_n;
  logic               sa_precharge;
  logic               sa_meas_complete;
  logic [IDX_W-1:0]   sa_idx;
  logic               measure_valid;
  out_pins_t          pins;

  spi_register_set u_spi_register_set (
    .sck_i       (sck_i),
    .rst_n_i     (rst_n_i),
    .cs_fpga_n_i (cs_fpga_n),
    .sdi_i       (sdi_i),
    .sdo_o       (sdo_o),
    .sa_status_i (sa_status),
    .hw_flags_i  (hw_flags_i),
    .sa_cfg_o    (sa_cfg),
    .mode_o      (mode),
    .direct_o    (direct),
    .oe_4094_o   (spi_4094_oe_o)
  );

  sequence_acquisition u_sequence_acquisition (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .sa_trig_i       (sa_trig_i),
    .sa_cfg_i        (sa_cfg),
    .measure_valid_i (measure_valid),
    .pc_sw_o         (sa_pc_sw),
    .azmux_o         (sa_azmux),
    .adc_reset_n_o   (sa_adc_reset_n),
    .precharge_o     (sa_precharge),
    .meas_complete_o (sa_meas_complete),
    .idx_o           (sa_idx),
    .sa_status_o     (sa_status)
  );

  adc_mock u_adc_mock (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .adc_reset_n_i   (sa_adc_reset_n),
    .aperture_i      (sa_cfg.aperture),
    .measure_valid_o (measure_valid)
  );

  pin_mux u_pin_mux (
    .spi_cs_vec_i        (spi_cs_vec_i),
    .sck_i               (sck_i),
    .sdi_i               (sdi_i),
    .mode_i              (mode),
    .direct_i            (direct),
    .pc_sw_i             (sa_pc_sw),
    .azmux_i             (sa_azmux),
    .precharge_i         (sa_precharge),
    .measure_valid_i     (measure_valid),
    .adc_reset_n_i       (sa_adc_reset_n),
    .meas_complete_i     (sa_meas_complete),
    .idx_i               (sa_idx),
    .cs_fpga_n_o         (cs_fpga_n),
    .spi_glb_clk_o       (spi_glb_clk_o),
    .spi_glb_mosi_o      (spi_glb_mosi_o),
    .spi_4094_strobe_o   (spi_4094_strobe_o),
    .spi_invert_dac_ss_o (spi_invert_dac_ss_o),
    .spi_iso_cs_o        (spi_iso_cs_o),
    .pins_o              (pins)
  );

  // pin word out to the pads
  assign leds_o          = pins.leds;
  assign monitor_o       = pins.monitor;
  assign pc_sw_o         = pins.pc_sw;
  assign azmux_o         = pins.azmux;
  assign meas_complete_o = pins.meas_complete;
  assign spi_interrupt_o = pins.spi_interrupt;

endmodule

//--- pin_mux.sv
/* spi line decode and pin mode mux */
module pin_mux import dmm_pkg::*; (
  input  logic [CS_W-1:0]    spi_cs_vec_i,
  input  logic               sck_i,
  input  logic               sdi_i,
  input  logic [MODE_W-1:0]  mode_i,
  input  pin_word_u          direct_i,
  // sequencer
  input  logic [PC_SW_W-1:0] pc_sw_i,
  input  logic [AZMUX_W-1:0] azmux_i,
  input  logic               precharge_i,
  input  logic               measure_valid_i,
  input  logic               adc_reset_n_i,
  input  logic               meas_complete_i,
  input  logic [IDX_W-1:0]   idx_i,
  // spi lines
  output logic               cs_fpga_n_o,
  output logic               spi_glb_clk_o,
  output logic               spi_glb_mosi_o,
  output logic               spi_4094_strobe_o,
  output logic               spi_invert_dac_ss_o,
  output logic               spi_iso_cs_o,
  output out_pins_t          pins_o
);

  out_pins_t sa_pins;    // mode 6 pin word

  //////////////////////////////////////////////////
  // chip select decode
  always_comb begin
    cs_fpga_n_o         = 1'b1;    // active lo, park hi
    spi_4094_strobe_o   = 1'b0;    // active hi, park lo
    spi_invert_dac_ss_o = 1'b1;
    spi_iso_cs_o        = 1'b1;
    case (spi_cs_vec_i)
      CS_DEASSERT:   ;
      CS_FPGA0:      cs_fpga_n_o         = 1'b0;
      CS_4094:       spi_4094_strobe_o   = 1'b1;
      CS_INVERT_DAC: spi_invert_dac_ss_o = 1'b0;
      CS_MDAC1:      spi_iso_cs_o        = 1'b0;
      default:       ;
    endcase
  end

  // shared lines silent while the register set is addressed
  assign spi_glb_clk_o  = cs_fpga_n_o ? sck_i : 1'b1;
  assign spi_glb_mosi_o = cs_fpga_n_o ? sdi_i : 1'b1;

  //////////////////////////////////////////////////
  // mode mux
  always_comb begin
    sa_pins               = '0;
    sa_pins.leds[idx_i]   = 1'b1;            // one-hot sample index
    sa_pins.monitor[0]    = precharge_i;
    sa_pins.monitor[1]    = measure_valid_i;
    sa_pins.monitor[2]    = adc_reset_n_i;
    sa_pins.pc_sw         = pc_sw_i;
    sa_pins.azmux         = azmux_i;
    sa_pins.meas_complete = meas_complete_i;
    sa_pins.spi_interrupt = meas_complete_i;  // mcu interrupt per sample
  end

  always_comb begin
    case (mode_i)
      MODE_DIRECT:  pins_o = direct_i.pins;
      MODE_SA_MOCK: pins_o = sa_pins;
      default:      pins_o = '0;             // unused modes, all lo
    endcase
  end

endmodule

//--- spi_register_set.sv
/* spi register set */
module spi_register_set import dmm_pkg::*; (
  input  logic                  sck_i,
  input  logic                  rst_n_i,
  input  logic                  cs_fpga_n_i,     // active lo
  input  logic                  sdi_i,
  output logic                  sdo_o,
  input  sa_status_t            sa_status_i,
  input  logic [HW_FLAGS_W-1:0] hw_flags_i,
  output sa_cfg_t               sa_cfg_o,
  output logic [MODE_W-1:0]     mode_o,
  output pin_word_u             direct_o,
  output logic                  oe_4094_o
);

  logic                   frame_rst_n;    // frame state cleared while deselected
  logic [FRAME_CNT_W-1:0] bit_cnt_q;      // rising edges so far
  logic [FRAME_W-2:0]     shift_q;
  spi_frame_t             frame;          // shift word incl. the current bit
  logic                   commit;
  logic [DATA_W-1:0]      rd_data;
  logic [DATA_W-1:0]      out_q;          // miso shifter

  assign frame_rst_n = rst_n_i && !cs_fpga_n_i;
  assign frame       = {shift_q, sdi_i};

  //////////////////////////////////////////////////
  // input shifter, msb first on rising sck
  always_ff @(posedge sck_i or negedge frame_rst_n) begin
    if (!frame_rst_n) begin
      bit_cnt_q <= '0;
      shift_q   <= '0;
    end else begin
      bit_cnt_q <= bit_cnt_q + 1'b1;     // wraps after 32
      shift_q   <= frame[FRAME_W-2:0];
    end
  end

  // 32nd rising edge
  assign commit = !cs_fpga_n_i && (bit_cnt_q == FRAME_CNT_W'(FRAME_W - 1)) && frame.wr;

  //////////////////////////////////////////////////
  // config registers, quasi-static to the clk domain
  always_ff @(posedge sck_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sa_cfg_o  <= '0;
      mode_o    <= MODE_DIRECT;
      direct_o  <= '0;
      oe_4094_o <= 1'b0;    // 4094 outputs disabled at power up
    end else if (commit) begin
      case (frame.addr)
        REG_MODE:      mode_o             <= frame.data[MODE_W-1:0];
        REG_DIRECT:    direct_o.raw       <= frame.data[PIN_W-1:0];
        REG_4094_OE:   oe_4094_o          <= frame.data[0];
        REG_PRECHARGE: sa_cfg_o.precharge <= frame.data[CNT_W-1:0];
        REG_APERTURE:  sa_cfg_o.aperture  <= frame.data[CNT_W-1:0];
        REG_SEQ_N:     sa_cfg_o.seq_n     <= frame.data[SEQ_N_W-1:0];
        REG_SEQ0:      sa_cfg_o.seq[0]    <= frame.data[$bits(seq_word_t)-1:0];
        REG_SEQ1:      sa_cfg_o.seq[1]    <= frame.data[$bits(seq_word_t)-1:0];
        REG_SEQ2:      sa_cfg_o.seq[2]    <= frame.data[$bits(seq_word_t)-1:0];
        REG_SEQ3:      sa_cfg_o.seq[3]    <= frame.data[$bits(seq_word_t)-1:0];
        default: ;    // status is read only
      endcase
    end
  end

  //////////////////////////////////////////////////
  // readback, addressed by the first byte
  always_comb begin
    rd_data = '0;
    case (shift_q[ADDR_W-1:0])
      REG_STATUS: begin
        rd_data[7:0]                        = STATUS_MAGIC;
        rd_data[STAT_HW_LSB +: HW_FLAGS_W]  = hw_flags_i;
        rd_data[STAT_IDX_LSB +: IDX_W]      = sa_status_i.idx_last;
        rd_data[STAT_SEQ_N_LSB +: SEQ_N_W]  = sa_status_i.seq_n;
      end
      REG_MODE:      rd_data[MODE_W-1:0]  = mode_o;
      REG_DIRECT:    rd_data[PIN_W-1:0]   = direct_o.raw;
      REG_4094_OE:   rd_data[0]           = oe_4094_o;
      REG_PRECHARGE: rd_data[CNT_W-1:0]   = sa_cfg_o.precharge;
      REG_APERTURE:  rd_data[CNT_W-1:0]   = sa_cfg_o.aperture;
      REG_SEQ_N:     rd_data[SEQ_N_W-1:0] = sa_cfg_o.seq_n;
      REG_SEQ0:      rd_data[$bits(seq_word_t)-1:0] = sa_cfg_o.seq[0];
      REG_SEQ1:      rd_data[$bits(seq_word_t)-1:0] = sa_cfg_o.seq[1];
      REG_SEQ2:      rd_data[$bits(seq_word_t)-1:0] = sa_cfg_o.seq[2];
      REG_SEQ3:      rd_data[$bits(seq_word_t)-1:0] = sa_cfg_o.seq[3];
      default:       rd_data = '0;
    endcase
  end

  // output shifter on falling sck
  // loads after the 8th rising edge, bit 23 ready before the 9th
  always_ff @(negedge sck_i or negedge frame_rst_n) begin
    if (!frame_rst_n) begin
      out_q <= '0;
    end else if (bit_cnt_q == FRAME_CNT_W'(ADDR_W + 1)) begin
      out_q <= rd_data;
    end else begin
      out_q <= {out_q[DATA_W-2:0], 1'b0};
    end
  end

  assign sdo_o = !cs_fpga_n_i && out_q[DATA_W-1];   // lo when not selected

endmodule

//--- sequence_acquisition.sv
/* sequence acquisition controller */
module sequence_acquisition import dmm_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               sa_trig_i,          // async from the mcu
  input  sa_cfg_t            sa_cfg_i,
  input  logic               measure_valid_i,    // fan in from adc
  output logic [PC_SW_W-1:0] pc_sw_o,
  output logic [AZMUX_W-1:0] azmux_o,
  output logic               adc_reset_n_o,
  output logic               precharge_o,
  output logic               meas_complete_o,
  output logic [IDX_W-1:0]   idx_o,
  output sa_status_t         sa_status_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_PRECHARGE,
    ST_SAMPLE
  } state_e;

  state_e             state_q;
  logic               trig_meta_q;
  logic               trig_q;          // synchronized trigger
  logic [IDX_W-1:0]   idx_q;
  logic [IDX_W-1:0]   idx_last_q;
  logic [IDX_W-1:0]   idx_next;
  logic [SEQ_N_W-1:0] seq_len;         // clamped 1..SEQ_LEN_MAX
  logic               run;
  logic               sample_done;
  logic               precharge_load;
  logic               precharge_done;
  seq_word_t          entry;

  //////////////////////////////////////////////////
  // trigger synchronizer
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      trig_meta_q <= 1'b0;
      trig_q      <= 1'b0;
    end else begin
      trig_meta_q <= sa_trig_i;
      trig_q      <= trig_meta_q;
    end
  end

  assign entry = sa_cfg_i.seq[idx_q];    // current table entry

  always_comb begin
    if (sa_cfg_i.seq_n == '0) begin
      seq_len = SEQ_N_W'(1);
    end else if (sa_cfg_i.seq_n > SEQ_N_W'(SEQ_LEN_MAX)) begin
      seq_len = SEQ_N_W'(SEQ_LEN_MAX);
    end else begin
      seq_len = sa_cfg_i.seq_n;
    end
    // wrap modulo the length
    if (SEQ_N_W'(idx_q) + 1'b1 >= seq_len) begin
      idx_next = '0;
    end else begin
      idx_next = idx_q + 1'b1;
    end
  end

  assign sample_done    = (state_q == ST_SAMPLE) && measure_valid_i;
  assign precharge_load = trig_q && ((state_q == ST_IDLE) || sample_done);

  // precharge phase timer
  clk_counter u_precharge (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .load_i  (precharge_load),
    .count_i (sa_cfg_i.precharge),
    .done_o  (precharge_done)
  );

  //////////////////////////////////////////////////
  // fsm
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= ST_IDLE;
      idx_q      <= '0;
      idx_last_q <= '0;
    end else if (!trig_q) begin
      state_q <= ST_IDLE;       // idx_last kept for the status read
      idx_q   <= '0;
    end else begin
      case (state_q)
        ST_IDLE: state_q <= ST_PRECHARGE;
        ST_PRECHARGE: begin
          if (precharge_done) state_q <= ST_SAMPLE;
        end
        ST_SAMPLE: begin
          if (measure_valid_i) begin
            state_q    <= ST_PRECHARGE;   // adc back in reset
            idx_last_q <= idx_q;
            idx_q      <= idx_next;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // outputs drop as soon as the synced trigger does
  assign run             = trig_q && (state_q != ST_IDLE);
  assign pc_sw_o         = run ? entry.pc_sw : '0;
  assign azmux_o         = run ? entry.azmux : '0;
  assign precharge_o     = trig_q && (state_q == ST_PRECHARGE);
  assign adc_reset_n_o   = trig_q && (state_q == ST_SAMPLE);   // released in sample only
  assign meas_complete_o = trig_q && sample_done;
  assign idx_o           = idx_q;

  assign sa_status_o.idx_last = idx_last_q;
  assign sa_status_o.seq_n    = sa_cfg_i.seq_n;

endmodule

//--- adc_mock.sv
/* mocked adc */
module adc_mock import dmm_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             adc_reset_n_i,    // from the sequencer
  input  logic [CNT_W-1:0] aperture_i,
  output logic             measure_valid_o
);

  logic adc_run_q;        // adc reset released, one cycle late
  logic aperture_done;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      adc_run_q <= 1'b0;
    end else begin
      adc_run_q <= adc_reset_n_i;
    end
  end

  // held loaded through reset and the first released cycle
  // so the aperture starts counting on release
  clk_counter u_aperture (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .load_i  (!adc_run_q),
    .count_i (aperture_i),
    .done_o  (aperture_done)
  );

  // a done while still in reset is dropped
  // counter goes idle after the strobe, so one per release
  assign measure_valid_o = aperture_done && adc_run_q && adc_reset_n_i;

endmodule

//--- clk_counter.sv
/* clock count timer */
module clk_counter import dmm_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             load_i,     // start, or restart
  input  logic [CNT_W-1:0] count_i,
  output logic             done_o      // one cycle, count_i cycles after load
);

  logic [CNT_W-1:0] cnt_q;
  logic             busy_q;

  // strobe on the last counted cycle
  assign done_o = busy_q && (cnt_q == CNT_W'(1));

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q  <= '0;
      busy_q <= 1'b0;
    end else if (load_i) begin
      cnt_q  <= (count_i == '0) ? CNT_W'(1) : count_i;   // 0 runs as 1
      busy_q <= 1'b1;
    end else if (busy_q) begin
      cnt_q  <= cnt_q - 1'b1;
      busy_q <= !done_o;      // stop after the strobe
    end
  end

endmodule

//--- dmm_pkg.sv
/* dmm control fpga definitions */
package dmm_pkg;

  //////////////////////////////////////////////////
  // widths
  localparam int CNT_W       = 24;              // clock counts
  localparam int SEQ_LEN_MAX = 4;               // sequence table entries
  localparam int IDX_W       = 2;
  localparam int SEQ_N_W     = 3;
  localparam int FRAME_W     = 32;              // spi frame bits
  localparam int FRAME_CNT_W = $clog2(FRAME_W);
  localparam int ADDR_W      = 7;
  localparam int DATA_W      = 24;
  localparam int MODE_W      = 3;
  localparam int CS_W        = 3;
  localparam int HW_FLAGS_W  = 4;
  localparam int PIN_W       = 20;              // output pin word
  localparam int LED_W       = 4;
  localparam int MON_W       = 8;
  localparam int PC_SW_W     = 2;
  localparam int AZMUX_W     = 4;

  // status word layout
  localparam logic [7:0] STATUS_MAGIC   = 8'haa;
  localparam int         STAT_HW_LSB    = 8;
  localparam int         STAT_IDX_LSB   = 12;
  localparam int         STAT_SEQ_N_LSB = 16;

  //////////////////////////////////////////////////
  // register map
  localparam logic [ADDR_W-1:0] REG_STATUS    = 7'd0;    // read only
  localparam logic [ADDR_W-1:0] REG_MODE      = 7'd1;
  localparam logic [ADDR_W-1:0] REG_DIRECT    = 7'd2;
  localparam logic [ADDR_W-1:0] REG_4094_OE   = 7'd3;
  localparam logic [ADDR_W-1:0] REG_PRECHARGE = 7'd4;
  localparam logic [ADDR_W-1:0] REG_APERTURE  = 7'd5;
  localparam logic [ADDR_W-1:0] REG_SEQ_N     = 7'd6;
  localparam logic [ADDR_W-1:0] REG_SEQ0      = 7'd7;
  localparam logic [ADDR_W-1:0] REG_SEQ1      = 7'd8;
  localparam logic [ADDR_W-1:0] REG_SEQ2      = 7'd9;
  localparam logic [ADDR_W-1:0] REG_SEQ3      = 7'd10;

  // modes, alternate function of the pins
  localparam logic [MODE_W-1:0] MODE_DIRECT  = 3'd0;
  localparam logic [MODE_W-1:0] MODE_SA_MOCK = 3'd6;     // sequencer + mocked adc

  // chip select vector line encoding
  localparam logic [CS_W-1:0] CS_DEASSERT   = 3'd0;
  localparam logic [CS_W-1:0] CS_FPGA0      = 3'd1;
  localparam logic [CS_W-1:0] CS_4094       = 3'd2;
  localparam logic [CS_W-1:0] CS_INVERT_DAC = 3'd3;
  localparam logic [CS_W-1:0] CS_MDAC1      = 3'd4;

  //////////////////////////////////////////////////
  // types
  typedef struct packed {
    logic              wr;       // bit 31
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } spi_frame_t;

  typedef struct packed {
    logic [AZMUX_W-1:0] azmux;
    logic [PC_SW_W-1:0] pc_sw;
  } seq_word_t;

  typedef struct packed {
    logic [CNT_W-1:0]                precharge;
    logic [CNT_W-1:0]                aperture;
    logic [SEQ_N_W-1:0]              seq_n;
    seq_word_t [SEQ_LEN_MAX-1:0]     seq;
  } sa_cfg_t;

  // msb first, leds at bit 0
  typedef struct packed {
    logic               meas_complete;   // 19
    logic               spi_interrupt;   // 18
    logic [AZMUX_W-1:0] azmux;           // 17..14
    logic [PC_SW_W-1:0] pc_sw;           // 13..12
    logic [MON_W-1:0]   monitor;         // 11..4
    logic [LED_W-1:0]   leds;            // 3..0
  } out_pins_t;

  typedef union packed {
    logic [PIN_W-1:0] raw;               // as written over spi
    out_pins_t        pins;
  } pin_word_u;

  typedef struct packed {
    logic [IDX_W-1:0]   idx_last;
    logic [SEQ_N_W-1:0] seq_n;
  } sa_status_t;

endpackage
